// File: hw/core_defines.svh
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// ------------------------------
// Word size
// ------------------------------
`define WORD_W 16 // Data and instruction

// ------------------------------
// Register file
// ------------------------------
`define REG_CNT 8
`define REG_IDX_W 3

// ------------------------------
// Data memory
// ------------------------------
`define DMEM_DEPTH 64 // In words
`define DMEM_ADDR_W 6

`endif

// File: hw/isa_pkg.sv
package isa_pkg;

	// Group ranges: imm arith 0100x, imm logic 0101x, imm shift 101xx, ALU1 1101x
	typedef enum logic [4:0] {
		OP_HALT   = 5'b00000,
		OP_NOP    = 5'b00001,
		OP_SIIC   = 5'b00010, // No-op here
		OP_RTI    = 5'b00011, // No-op here
		OP_J      = 5'b00100,
		OP_JR     = 5'b00101,
		OP_JAL    = 5'b00110,
		OP_JALR   = 5'b00111,
		OP_ADDI   = 5'b01000,
		OP_SUBI   = 5'b01001,
		OP_XORI   = 5'b01010,
		OP_ANDNI  = 5'b01011,
		OP_BEQZ   = 5'b01100,
		OP_BNEZ   = 5'b01101,
		OP_BLTZ   = 5'b01110,
		OP_BGEZ   = 5'b01111,
		OP_ST     = 5'b10000,
		OP_LD     = 5'b10001,
		OP_SLBI   = 5'b10010,
		OP_STU    = 5'b10011,
		OP_ROLI   = 5'b10100,
		OP_SLLI   = 5'b10101,
		OP_RORI   = 5'b10110,
		OP_SRLI   = 5'b10111,
		OP_LBI    = 5'b11000,
		OP_BTR    = 5'b11001,
		OP_ALU_SH = 5'b11010, // ROL SLL ROR SRL by func
		OP_ALU_AR = 5'b11011, // ADD SUB XOR ANDN by func
		OP_SEQ    = 5'b11100,
		OP_SLT    = 5'b11101,
		OP_SLE    = 5'b11110,
		OP_SCO    = 5'b11111
	} opcode_t;

	typedef logic [1:0] func_t; // R-format function

	// ------------------------------
	// Field positions
	// ------------------------------
	localparam int OPC_HI = 15;
	localparam int OPC_LO = 11;
	localparam int RS_HI = 10;
	localparam int RS_LO = 8;
	localparam int RT_HI = 7;
	localparam int RT_LO = 5;
	localparam int RD_R_HI = 4;
	localparam int RD_R_LO = 2;
	localparam int RD_I1_HI = 7;
	localparam int RD_I1_LO = 5;
	localparam int FN_HI = 1;
	localparam int FN_LO = 0;

	localparam int INSTR_BYTES = 2; // PC step

endpackage

// File: hw/datapath_pkg.sv
package datapath_pkg;

	typedef enum logic [3:0] {
		ALU_ROL  = 4'h0,
		ALU_SLL  = 4'h1,
		ALU_ROR  = 4'h2,
		ALU_SRL  = 4'h3,
		ALU_ADD  = 4'h4,
		ALU_SUB  = 4'h5, // B minus A
		ALU_XOR  = 4'h6,
		ALU_ANDN = 4'h7,
		ALU_PASS = 4'h8,
		ALU_BTR  = 4'h9,
		ALU_SLBI = 4'ha,
		ALU_CMP  = 4'hb
	} alu_op_t;

	typedef enum logic [1:0] {DST_RS, DST_R, DST_LINK, DST_I1} reg_dst_t;

	typedef enum logic [1:0] {WB_MEM, WB_ALU, WB_PC2, WB_IMM} wb_sel_t;

	typedef enum logic [1:0] {SRC_REG, SRC_IMM, SRC_IMM_SH} alu_src_t;

	typedef enum logic [1:0] {IMM_S5, IMM_S8, IMM_Z5, IMM_D11} imm_kind_t;

	typedef enum logic [1:0] {SET_EQ, SET_LT, SET_LE, SET_CO} set_cond_t;

endpackage

// File: hw/control.sv
`timescale 1ns/100ps

module control
	import isa_pkg::*;
	import datapath_pkg::*;
(
	input  opcode_t   i_opcode,
	input  func_t     i_func,
	output reg_dst_t  o_reg_dst,
	output wb_sel_t   o_wb_sel,
	output alu_src_t  o_alu_src,
	output alu_op_t   o_alu_op,
	output logic      o_alu_signed,
	output logic      o_reg_write,
	output logic      o_mem_read,
	output logic      o_mem_write,
	output logic      o_branch,
	output logic      o_br_eq,
	output logic      o_br_gt,
	output logic      o_br_lt,
	output logic      o_jump,
	output logic      o_jr,
	output imm_kind_t o_imm_kind,
	output logic      o_set_sel,
	output set_cond_t o_set_cond,
	output logic      o_halt,
	output logic      o_err
);

	always_comb begin
		o_reg_dst    = DST_RS;
		o_wb_sel     = WB_ALU;
		o_alu_src    = SRC_REG;
		o_alu_op     = ALU_PASS;
		o_alu_signed = 1'b0;
		o_reg_write  = 1'b0;
		o_mem_read   = 1'b0;
		o_mem_write  = 1'b0;
		o_branch     = 1'b0;
		o_br_eq      = 1'b0;
		o_br_gt      = 1'b0;
		o_br_lt      = 1'b0;
		o_jump       = 1'b0;
		o_jr         = 1'b0;
		o_imm_kind   = IMM_S5;
		o_set_sel    = 1'b0;
		o_set_cond   = SET_EQ;
		o_halt       = 1'b0;
		o_err        = 1'b0;

		case (i_opcode) inside
			OP_HALT: begin
				o_halt = 1'b1;
			end
			OP_NOP, OP_SIIC, OP_RTI: begin
			end
			// ------------------------------
			// I1 format
			// ------------------------------
			[OP_ADDI:OP_SUBI]: begin
				o_reg_dst   = DST_I1;
				o_alu_src   = SRC_IMM;
				o_alu_op    = alu_op_t'({2'b01, i_opcode[1:0]});
				o_reg_write = 1'b1;
			end
			[OP_XORI:OP_ANDNI]: begin
				o_reg_dst   = DST_I1;
				o_alu_src   = SRC_IMM;
				o_alu_op    = alu_op_t'({2'b01, i_opcode[1:0]});
				o_imm_kind  = IMM_Z5; // Logic ops zero-extend
				o_reg_write = 1'b1;
			end
			[OP_ROLI:OP_SRLI]: begin
				o_reg_dst   = DST_I1;
				o_alu_src   = SRC_IMM;
				o_alu_op    = alu_op_t'({2'b00, i_opcode[1:0]});
				o_reg_write = 1'b1;
			end
			OP_ST: begin
				o_alu_src   = SRC_IMM;
				o_alu_op    = ALU_ADD;
				o_mem_write = 1'b1;
			end
			OP_LD: begin
				o_reg_dst   = DST_I1;
				o_alu_src   = SRC_IMM;
				o_alu_op    = ALU_ADD;
				o_wb_sel    = WB_MEM;
				o_reg_write = 1'b1;
				o_mem_read  = 1'b1;
			end
			OP_STU: begin
				o_alu_src   = SRC_IMM;
				o_alu_op    = ALU_ADD;
				o_reg_write = 1'b1; // Base gets the address
				o_mem_write = 1'b1;
			end
			// ------------------------------
			// R format
			// ------------------------------
			OP_BTR: begin
				o_reg_dst   = DST_R;
				o_alu_op    = ALU_BTR;
				o_reg_write = 1'b1;
			end
			[OP_ALU_SH:OP_ALU_AR]: begin
				o_reg_dst   = DST_R;
				o_alu_op    = alu_op_t'({1'b0, i_opcode[0], i_func});
				o_reg_write = 1'b1;
			end
			[OP_SEQ:OP_SCO]: begin
				o_reg_dst    = DST_R;
				o_alu_op     = ALU_CMP;
				o_alu_signed = (i_opcode == OP_SLT) || (i_opcode == OP_SLE);
				o_set_sel    = 1'b1;
				o_set_cond   = set_cond_t'(i_opcode[1:0]);
				o_reg_write  = 1'b1;
			end
			// ------------------------------
			// I2 and J format
			// ------------------------------
			[OP_BEQZ:OP_BGEZ]: begin
				o_branch   = 1'b1;
				o_imm_kind = IMM_S8;
				o_br_eq    = (i_opcode == OP_BEQZ) || (i_opcode == OP_BGEZ);
				o_br_gt    = (i_opcode == OP_BNEZ) || (i_opcode == OP_BGEZ);
				o_br_lt    = (i_opcode == OP_BNEZ) || (i_opcode == OP_BLTZ);
			end
			OP_LBI: begin
				o_wb_sel    = WB_IMM;
				o_imm_kind  = IMM_S8;
				o_reg_write = 1'b1;
			end
			OP_SLBI: begin
				o_alu_src   = SRC_IMM_SH;
				o_alu_op    = ALU_SLBI;
				o_imm_kind  = IMM_S8;
				o_reg_write = 1'b1;
			end
			OP_JR, OP_JALR: begin
				o_jr        = 1'b1;
				o_alu_src   = SRC_IMM;
				o_alu_op    = ALU_ADD; // rs + imm8
				o_imm_kind  = IMM_S8;
				o_reg_dst   = DST_LINK;
				o_wb_sel    = WB_PC2;
				o_reg_write = (i_opcode == OP_JALR);
			end
			OP_J, OP_JAL: begin
				o_jump      = 1'b1;
				o_imm_kind  = IMM_D11;
				o_reg_dst   = DST_LINK;
				o_wb_sel    = WB_PC2;
				o_reg_write = (i_opcode == OP_JAL);
			end
			default: o_err = 1'b1;
		endcase
	end

endmodule

// File: hw/alu.sv
`timescale 1ns/100ps

`include "core_defines.svh"

module alu
	import datapath_pkg::*;
(
	input  logic [`WORD_W-1:0] i_a,
	input  logic [`WORD_W-1:0] i_b,
	input  alu_op_t            i_op,
	input  logic               i_signed,
	input  logic               i_set_sel,
	input  set_cond_t          i_set_cond,
	output logic [`WORD_W-1:0] o_result,
	output logic               o_zero,
	output logic               o_neg
);

	logic [3:0] shamt;
	logic [`WORD_W:0] sum; // Carry on top
	logic [2*`WORD_W-1:0] rol_w;
	logic [2*`WORD_W-1:0] ror_w;
	logic [`WORD_W-1:0] rev;
	logic [`WORD_W-1:0] op_res;
	logic a_lt_b;
	logic set_bit;

	assign shamt = i_b[3:0];
	assign sum = {1'b0, i_a} + {1'b0, i_b};
	assign rol_w = {i_a, i_a} << shamt;
	assign ror_w = {i_a, i_a} >> shamt;
	assign a_lt_b = i_signed ? ($signed(i_a) < $signed(i_b)) : (i_a < i_b);

	always_comb begin
		for (int i = 0; i < `WORD_W; i++) begin
			rev[i] = i_a[`WORD_W-1-i];
		end
	end

	always_comb begin
		case (i_set_cond)
			SET_EQ: set_bit = (i_a == i_b);
			SET_LT: set_bit = a_lt_b;
			SET_LE: set_bit = a_lt_b | (i_a == i_b);
			default: set_bit = sum[`WORD_W]; // Carry out
		endcase
	end

	always_comb begin
		case (i_op)
			ALU_ROL:  op_res = rol_w[2*`WORD_W-1:`WORD_W];
			ALU_SLL:  op_res = i_a << shamt;
			ALU_ROR:  op_res = ror_w[`WORD_W-1:0];
			ALU_SRL:  op_res = i_a >> shamt;
			ALU_ADD:  op_res = sum[`WORD_W-1:0];
			ALU_SUB:  op_res = i_b - i_a;
			ALU_XOR:  op_res = i_a ^ i_b;
			ALU_ANDN: op_res = i_a & ~i_b;
			ALU_BTR:  op_res = rev;
			ALU_SLBI: op_res = (i_a << 8) | i_b; // Low byte arrives in B
			ALU_CMP:  op_res = i_a - i_b;
			default:  op_res = i_a; // Pass A
		endcase
	end

	assign o_result = i_set_sel ? {{(`WORD_W-1){1'b0}}, set_bit} : op_res;
	assign o_zero = (i_a == '0);
	assign o_neg = i_a[`WORD_W-1];

endmodule

// File: hw/reg_file.sv
`timescale 1ns/100ps

`include "core_defines.svh"

module reg_file (
	input  logic                  clk,
	input  logic                  i_rst_n,
	input  logic [`REG_IDX_W-1:0] i_rd_a,
	input  logic [`REG_IDX_W-1:0] i_rd_b,
	output logic [`WORD_W-1:0]    o_data_a,
	output logic [`WORD_W-1:0]    o_data_b,
	input  logic                  i_we,
	input  logic [`REG_IDX_W-1:0] i_wr_idx,
	input  logic [`WORD_W-1:0]    i_wr_data
);

	logic [`WORD_W-1:0] regs [`REG_CNT];

	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			for (int i = 0; i < `REG_CNT; i++) begin
				regs[i] <= '0;
			end
		end else if (i_we) begin
			regs[i_wr_idx] <= i_wr_data;
		end
	end

	// Reads see the value from before this edge
	assign o_data_a = regs[i_rd_a];
	assign o_data_b = regs[i_rd_b];

endmodule

// File: hw/fetch_unit.sv
`timescale 1ns/100ps

`include "core_defines.svh"

module fetch_unit
	import isa_pkg::*;
(
	input  logic               clk,
	input  logic               i_rst_n,
	input  logic               i_branch,
	input  logic               i_br_eq,
	input  logic               i_br_gt,
	input  logic               i_br_lt,
	input  logic               i_zero,
	input  logic               i_neg,
	input  logic               i_jump,
	input  logic               i_jr,
	input  logic [`WORD_W-1:0] i_imm,
	input  logic [`WORD_W-1:0] i_jr_target,
	input  logic               i_stop,
	output logic [`WORD_W-1:0] o_pc,
	output logic [`WORD_W-1:0] o_pc_plus2,
	output logic               o_halted
);

	logic br_taken;
	logic [`WORD_W-1:0] rel_target;
	logic [`WORD_W-1:0] pc_next;

	assign o_pc_plus2 = o_pc + `WORD_W'(INSTR_BYTES);
	assign rel_target = o_pc_plus2 + i_imm;
	assign br_taken = i_branch & ((i_br_eq & i_zero) | (i_br_lt & i_neg) |
		(i_br_gt & ~i_zero & ~i_neg));

	always_comb begin
		if (i_jr)
			pc_next = {i_jr_target[`WORD_W-1:1], 1'b0}; // Register target forced even
		else if (i_jump | br_taken)
			pc_next = rel_target;
		else
			pc_next = o_pc_plus2;
	end

	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			o_pc <= '0;
			o_halted <= 1'b0;
		end else if (i_stop | o_halted) begin
			o_halted <= 1'b1; // PC holds
		end else begin
			o_pc <= pc_next;
		end
	end

	a_pc_even: assert property (@(posedge clk) disable iff (!i_rst_n) o_pc[0] == 1'b0);

endmodule

// File: hw/data_mem.sv
`timescale 1ns/100ps

`include "core_defines.svh"

module data_mem (
	input  logic               clk,
	input  logic               i_rst_n,
	input  logic [`WORD_W-1:0] i_addr,
	input  logic               i_we,
	input  logic [`WORD_W-1:0] i_wdata,
	output logic [`WORD_W-1:0] o_rdata
);

	logic [`WORD_W-1:0] mem [`DMEM_DEPTH];
	logic [`DMEM_ADDR_W-1:0] widx;

	assign widx = i_addr[`DMEM_ADDR_W:1]; // Bit 0 is the byte lane

	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			for (int i = 0; i < `DMEM_DEPTH; i++) begin
				mem[i] <= '0;
			end
		end else if (i_we) begin
			mem[widx] <= i_wdata;
		end
	end

	assign o_rdata = mem[widx];

endmodule

// File: hw/wisc_core.sv
`timescale 1ns/100ps

`include "core_defines.svh"

module wisc_core
	import isa_pkg::*;
	import datapath_pkg::*;
(
	input  logic                  clk,
	input  logic                  i_rst_n,
	input  logic [`WORD_W-1:0]    i_instr,
	output logic [`WORD_W-1:0]    o_pc,
	output logic                  o_halt,
	output logic                  o_err,
	output logic                  o_wb_en,
	output logic [`REG_IDX_W-1:0] o_wb_reg,
	output logic [`WORD_W-1:0]    o_wb_data
);

	// ------------------------------
	// Decode outputs
	// ------------------------------
	reg_dst_t reg_dst;
	wb_sel_t wb_sel;
	alu_src_t alu_src;
	alu_op_t alu_op;
	imm_kind_t imm_kind;
	set_cond_t set_cond;
	logic alu_signed;
	logic reg_write;
	logic mem_read;
	logic mem_write;
	logic branch;
	logic br_eq;
	logic br_gt;
	logic br_lt;
	logic jump;
	logic jr;
	logic set_sel;
	logic dec_halt;
	logic dec_err;

	// ------------------------------
	// Datapath
	// ------------------------------
	logic [`WORD_W-1:0] imm;
	logic [`WORD_W-1:0] rs_data;
	logic [`WORD_W-1:0] rt_data;
	logic [`WORD_W-1:0] alu_b;
	logic [`WORD_W-1:0] alu_result;
	logic [`WORD_W-1:0] dmem_rdata;
	logic [`WORD_W-1:0] load_data;
	logic [`WORD_W-1:0] pc_plus2;
	logic zero;
	logic neg;
	logic halted;
	logic err_q;

	control control_i (
		.i_opcode(opcode_t'(i_instr[OPC_HI:OPC_LO])),
		.i_func(i_instr[FN_HI:FN_LO]),
		.o_reg_dst(reg_dst),
		.o_wb_sel(wb_sel),
		.o_alu_src(alu_src),
		.o_alu_op(alu_op),
		.o_alu_signed(alu_signed),
		.o_reg_write(reg_write),
		.o_mem_read(mem_read),
		.o_mem_write(mem_write),
		.o_branch(branch),
		.o_br_eq(br_eq),
		.o_br_gt(br_gt),
		.o_br_lt(br_lt),
		.o_jump(jump),
		.o_jr(jr),
		.o_imm_kind(imm_kind),
		.o_set_sel(set_sel),
		.o_set_cond(set_cond),
		.o_halt(dec_halt),
		.o_err(dec_err)
	);

	always_comb begin
		case (imm_kind)
			IMM_S5:  imm = {{(`WORD_W-5){i_instr[4]}}, i_instr[4:0]};
			IMM_S8:  imm = {{(`WORD_W-8){i_instr[7]}}, i_instr[7:0]};
			IMM_Z5:  imm = {{(`WORD_W-5){1'b0}}, i_instr[4:0]};
			default: imm = {{(`WORD_W-11){i_instr[10]}}, i_instr[10:0]}; // J displacement
		endcase
	end

	always_comb begin
		case (alu_src)
			SRC_IMM:    alu_b = imm;
			SRC_IMM_SH: alu_b = {{(`WORD_W-8){1'b0}}, imm[7:0]}; // SLBI low byte
			default:    alu_b = rt_data;
		endcase
	end

	always_comb begin
		case (reg_dst)
			DST_RS:   o_wb_reg = i_instr[RS_HI:RS_LO];
			DST_R:    o_wb_reg = i_instr[RD_R_HI:RD_R_LO];
			DST_LINK: o_wb_reg = `REG_IDX_W'(`REG_CNT-1); // r7
			default:  o_wb_reg = i_instr[RD_I1_HI:RD_I1_LO];
		endcase
	end

	assign load_data = mem_read ? dmem_rdata : '0;

	always_comb begin
		case (wb_sel)
			WB_MEM:  o_wb_data = load_data;
			WB_PC2:  o_wb_data = pc_plus2;
			WB_IMM:  o_wb_data = imm;
			default: o_wb_data = alu_result;
		endcase
	end

	assign o_wb_en = reg_write & ~halted;

	reg_file reg_file_i (
		.clk(clk),
		.i_rst_n(i_rst_n),
		.i_rd_a(i_instr[RS_HI:RS_LO]),
		.i_rd_b(i_instr[RT_HI:RT_LO]), // rd of I1 is store data
		.o_data_a(rs_data),
		.o_data_b(rt_data),
		.i_we(o_wb_en),
		.i_wr_idx(o_wb_reg),
		.i_wr_data(o_wb_data)
	);

	alu alu_i (
		.i_a(rs_data),
		.i_b(alu_b),
		.i_op(alu_op),
		.i_signed(alu_signed),
		.i_set_sel(set_sel),
		.i_set_cond(set_cond),
		.o_result(alu_result),
		.o_zero(zero),
		.o_neg(neg)
	);

	fetch_unit fetch_unit_i (
		.clk(clk),
		.i_rst_n(i_rst_n),
		.i_branch(branch),
		.i_br_eq(br_eq),
		.i_br_gt(br_gt),
		.i_br_lt(br_lt),
		.i_zero(zero),
		.i_neg(neg),
		.i_jump(jump),
		.i_jr(jr),
		.i_imm(imm),
		.i_jr_target(alu_result),
		.i_stop(dec_halt | dec_err | err_q),
		.o_pc(o_pc),
		.o_pc_plus2(pc_plus2),
		.o_halted(halted)
	);

	data_mem data_mem_i (
		.clk(clk),
		.i_rst_n(i_rst_n),
		.i_addr(alu_result),
		.i_we(mem_write & ~halted),
		.i_wdata(rt_data),
		.o_rdata(dmem_rdata)
	);

	always_ff @(posedge clk) begin
		if (!i_rst_n)
			err_q <= 1'b0;
		else if (dec_err & ~halted)
			err_q <= 1'b1; // Sticky until reset
	end

	assign o_err = err_q;
	assign o_halt = halted & ~err_q; // Error stop is not a halt

endmodule

// File: verif/isa_model.svh
`ifndef ISA_MODEL_SVH
`define ISA_MODEL_SVH

// ------------------------------
// Shadow machine state
// ------------------------------
logic [`WORD_W-1:0] m_regs [`REG_CNT];
logic [`WORD_W-1:0] m_mem [`DMEM_DEPTH];
logic [`WORD_W-1:0] m_pc;
logic m_halted;

function automatic logic [15:0] rotl16(input logic [15:0] v, input logic [3:0] n);
	return (v << n) | (v >> (5'd16 - {1'b0, n}));
endfunction

function automatic logic [15:0] rotr16(input logic [15:0] v, input logic [3:0] n);
	return (v >> n) | (v << (5'd16 - {1'b0, n}));
endfunction

function automatic logic [15:0] bit_rev16(input logic [15:0] v);
	logic [15:0] r;
	for (int i = 0; i < 16; i++) begin
		r[i] = v[15-i];
	end
	return r;
endfunction

task automatic model_reset();
	for (int i = 0; i < `REG_CNT; i++) begin
		m_regs[i] = '0;
	end
	for (int i = 0; i < `DMEM_DEPTH; i++) begin
		m_mem[i] = '0;
	end
	m_pc = '0;
	m_halted = 1'b0;
endtask

task automatic model_exec(input logic [15:0] instr, output logic we, output logic [2:0] wreg,
	output logic [15:0] wdata);
	logic [2:0] rs;
	logic [2:0] rt;
	logic [2:0] rdr;
	logic [15:0] a;
	logic [15:0] b;
	logic [15:0] s5;
	logic [15:0] z5;
	logic [15:0] s8;
	logic [15:0] d11;
	logic [15:0] addr;
	logic [15:0] pc2;
	logic [15:0] nxt;
	logic [16:0] csum;
	rs = instr[10:8];
	rt = instr[7:5];
	rdr = instr[4:2];
	a = m_regs[rs];
	b = m_regs[rt];
	s5 = {{11{instr[4]}}, instr[4:0]};
	z5 = {11'b0, instr[4:0]};
	s8 = {{8{instr[7]}}, instr[7:0]};
	d11 = {{5{instr[10]}}, instr[10:0]};
	addr = a + s5;
	csum = {1'b0, a} + {1'b0, b};
	pc2 = m_pc + 16'd2;
	nxt = pc2;
	we = 1'b0;
	wreg = rt; // I1 destination unless changed
	wdata = '0;
	case (opcode_t'(instr[15:11]))
		OP_HALT: begin
			m_halted = 1'b1;
			nxt = m_pc;
		end
		OP_NOP, OP_SIIC, OP_RTI: begin
		end
		OP_J: nxt = pc2 + d11;
		OP_JAL: begin
			nxt = pc2 + d11;
			we = 1'b1;
			wreg = 3'd7;
			wdata = pc2;
		end
		OP_JR: nxt = (a + s8) & 16'hfffe;
		OP_JALR: begin
			nxt = (a + s8) & 16'hfffe;
			we = 1'b1;
			wreg = 3'd7;
			wdata = pc2;
		end
		OP_ADDI: begin we = 1'b1; wdata = a + s5; end
		OP_SUBI: begin we = 1'b1; wdata = s5 - a; end
		OP_XORI: begin we = 1'b1; wdata = a ^ z5; end
		OP_ANDNI: begin we = 1'b1; wdata = a & ~z5; end
		OP_BEQZ: if (a == 16'h0) nxt = pc2 + s8;
		OP_BNEZ: if (a != 16'h0) nxt = pc2 + s8;
		OP_BLTZ: if (a[15]) nxt = pc2 + s8;
		OP_BGEZ: if (!a[15]) nxt = pc2 + s8;
		OP_ST: m_mem[addr[6:1]] = b;
		OP_LD: begin we = 1'b1; wdata = m_mem[addr[6:1]]; end
		OP_STU: begin
			m_mem[addr[6:1]] = b;
			we = 1'b1;
			wreg = rs; // Base register update
			wdata = addr;
		end
		OP_SLBI: begin we = 1'b1; wreg = rs; wdata = (a << 8) | {8'h00, instr[7:0]}; end
		OP_LBI: begin we = 1'b1; wreg = rs; wdata = s8; end
		OP_ROLI: begin we = 1'b1; wdata = rotl16(a, instr[3:0]); end
		OP_SLLI: begin we = 1'b1; wdata = a << instr[3:0]; end
		OP_RORI: begin we = 1'b1; wdata = rotr16(a, instr[3:0]); end
		OP_SRLI: begin we = 1'b1; wdata = a >> instr[3:0]; end
		OP_BTR: begin we = 1'b1; wreg = rdr; wdata = bit_rev16(a); end
		OP_ALU_SH: begin
			we = 1'b1;
			wreg = rdr;
			case (instr[1:0])
				2'b00: wdata = rotl16(a, b[3:0]);
				2'b01: wdata = a << b[3:0];
				2'b10: wdata = rotr16(a, b[3:0]);
				default: wdata = a >> b[3:0];
			endcase
		end
		OP_ALU_AR: begin
			we = 1'b1;
			wreg = rdr;
			case (instr[1:0])
				2'b00: wdata = a + b;
				2'b01: wdata = b - a;
				2'b10: wdata = a ^ b;
				default: wdata = a & ~b;
			endcase
		end
		OP_SEQ: begin we = 1'b1; wreg = rdr; wdata = {15'b0, a == b}; end
		OP_SLT: begin we = 1'b1; wreg = rdr; wdata = {15'b0, $signed(a) < $signed(b)}; end
		OP_SLE: begin we = 1'b1; wreg = rdr; wdata = {15'b0, $signed(a) <= $signed(b)}; end
		OP_SCO: begin we = 1'b1; wreg = rdr; wdata = {15'b0, csum[16]}; end
	endcase
	if (we) begin
		m_regs[wreg] = wdata;
	end
	m_pc = nxt;
endtask

`endif

// File: verif/tb_wisc_core.sv
`timescale 1ns/100ps

`include "core_defines.svh"

module tb_wisc_core
	import isa_pkg::*;
();

	localparam int NUM_PROGS = 40;
	localparam int MAX_LEN = 40;
	localparam int RESET_CYCLES = 16;
	localparam int HALT_HOLD = 10;
	localparam int TIMEOUT_CYCLES = NUM_PROGS * MAX_LEN * 2;
	localparam logic [31:0] SEED = 32'h0b1b6b2a;

	logic clk;
	logic rst_n;
	logic [`WORD_W-1:0] i_instr;
	logic [`WORD_W-1:0] o_pc;
	logic o_halt;
	logic o_err;
	logic o_wb_en;
	logic [`REG_IDX_W-1:0] o_wb_reg;
	logic [`WORD_W-1:0] o_wb_data;

	logic [15:0] imem [1024];
	logic [15:0] prog [MAX_LEN];
	logic [31:0] lfsr_state;
	int cycle_count;

	`include "isa_model.svh"

	assign i_instr = imem[o_pc[10:1]]; // Combinational fetch

	wisc_core wisc_core_i (
		.clk(clk),
		.i_rst_n(rst_n),
		.i_instr(i_instr),
		.o_pc(o_pc),
		.o_halt(o_halt),
		.o_err(o_err),
		.o_wb_en(o_wb_en),
		.o_wb_reg(o_wb_reg),
		.o_wb_data(o_wb_data)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// ------------------------------
	// Error reporting
	// ------------------------------
	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic compare_word(input string name, input logic [15:0] got,
		input logic [15:0] exp);
		a_word: assert (got === exp) else begin
			fail_run($sformatf("MISMATCH %s got 0x%04h expected 0x%04h at pc 0x%04h",
				name, got, exp, m_pc));
		end
	endtask

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			fail_run("Timeout: the core did not finish the programs in time");
		end
	end

	// ------------------------------
	// Random program generation
	// ------------------------------
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	function automatic logic [15:0] rand_bits(input int n);
		logic [15:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[14:0], lfsr_state[0]};
		end
		return v;
	endfunction

	// r6 stays zero so JR targets are absolute
	function automatic logic [2:0] pick_dest();
		logic [2:0] v;
		v = 3'(rand_bits(3));
		return (v == 3'd6) ? 3'd5 : v;
	endfunction

	task automatic gen_program(output int len);
		logic [3:0] kind;
		logic [1:0] sel;
		logic [2:0] rs;
		logic [2:0] rt;
		logic [2:0] rd;
		logic [7:0] r8;
		logic [15:0] tgt;
		logic [15:0] w;
		len = 8 + int'(rand_bits(5)) % (MAX_LEN - 8);
		for (int pos = 0; pos < len; pos++) begin
			kind = 4'(rand_bits(4));
			sel = 2'(rand_bits(2));
			rs = 3'(rand_bits(3));
			rt = 3'(rand_bits(3));
			rd = pick_dest();
			r8 = 8'(rand_bits(8));
			tgt = 16'(2 * pos + 2) + {12'b0, r8[2:0], 1'b0};
			case (kind)
				4'd0: w = {4'b0100, sel[0], rs, rd, r8[4:0]};
				4'd1: w = {4'b0101, sel[0], rs, rd, r8[4:0]};
				4'd2: w = {3'b101, sel, rs, rd, r8[4:0]};
				4'd3: w = {5'b11010, rs, rt, rd, sel};
				4'd4: w = {5'b11011, rs, rt, rd, sel};
				4'd5: w = {3'b111, sel, rs, rt, rd, 2'b00};
				4'd6: w = {5'b11001, rs, 3'b000, rd, 2'b00};
				4'd7: w = {5'b11000, rd, r8};
				4'd8: w = {5'b10010, rd, r8};
				4'd9: w = {5'b10000, rs, rt, r8[4:0]};
				4'd10: w = {5'b10001, rs, rd, r8[4:0]};
				4'd11: w = {5'b10011, rd, rt, r8[4:0]};
				4'd12: w = {3'b011, sel, rs, 3'b000, r8[3:0], 1'b0}; // Forward branch
				4'd13: w = {3'b001, sel[0], 1'b0, 6'b0, r8[3:0], 1'b0};
				4'd14: begin
					if (tgt <= 16'd126)
						w = {3'b001, sel[0], 1'b1, 3'd6, tgt[7:0]};
					else
						w = {5'b00001, 11'h000};
				end
				default: w = {3'b000, (sel == 2'b00) ? 2'b01 : sel, 3'b000, r8};
			endcase
			prog[pos] = w;
		end
	endtask

	// HALT everywhere with the word address in the low bits
	task automatic fill_imem();
		for (int i = 0; i < 1024; i++) begin
			imem[i] = {6'b000000, 10'(i)};
		end
	endtask

	task automatic run_program();
		int len;
		int hold;
		logic [15:0] instr;
		logic exp_we;
		logic [2:0] exp_reg;
		logic [15:0] exp_data;
		gen_program(len);
		fill_imem();
		@(posedge clk);
		rst_n <= 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		compare_word("o_pc", o_pc, 16'h0000);
		compare_word("o_halt", {15'b0, o_halt}, 16'h0000);
		compare_word("o_err", {15'b0, o_err}, 16'h0000);
		compare_word("o_wb_en", {15'b0, o_wb_en}, 16'h0000);
		for (int i = 0; i < len; i++) begin
			imem[i] = prog[i];
		end
		imem[len] = 16'h0000; // HALT
		model_reset();
		@(posedge clk);
		rst_n <= 1'b1;
		hold = 0;
		while (hold < HALT_HOLD) begin
			@(negedge clk);
			compare_word("o_pc", o_pc, m_pc);
			compare_word("o_err", {15'b0, o_err}, 16'h0000);
			if (m_halted) begin
				compare_word("o_halt", {15'b0, o_halt}, 16'h0001);
				compare_word("o_wb_en", {15'b0, o_wb_en}, 16'h0000);
				hold++;
			end else begin
				compare_word("o_halt", {15'b0, o_halt}, 16'h0000);
				instr = imem[m_pc[10:1]];
				model_exec(instr, exp_we, exp_reg, exp_data);
				compare_word("o_wb_en", {15'b0, o_wb_en}, {15'b0, exp_we});
				if (exp_we) begin
					compare_word("o_wb_reg", {13'b0, o_wb_reg}, {13'b0, exp_reg});
					compare_word("o_wb_data", o_wb_data, exp_data);
				end
			end
		end
	endtask

	initial begin
		rst_n = 1'b0;
		lfsr_state = SEED;
		cycle_count = 0;
		fill_imem();
		for (int p = 0; p < NUM_PROGS; p++) begin
			run_program();
		end
		$display("Test completed successfully");
		$finish;
	end

endmodule

// File: verilog.f
+incdir+hw
+incdir+verif
hw/isa_pkg.sv
hw/datapath_pkg.sv
hw/control.sv
hw/alu.sv
hw/reg_file.sv
hw/fetch_unit.sv
hw/data_mem.sv
hw/wisc_core.sv
verif/tb_wisc_core.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_wisc_core
DUT_TOP   ?= wisc_core
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all run build lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "Test completed successfully" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
